// ==== logic/rv_isa_pkg.sv ====
`default_nettype none

package rv_isa_pkg;

  localparam int xlen          = 32;
  localparam int mem_words     = 256;
  localparam int mem_addr_bits = 8;

  // Opcodes of the supported RV32I subset.
  localparam logic [6:0] op_op    = 7'b0110011;
  localparam logic [6:0] op_imm   = 7'b0010011;
  localparam logic [6:0] op_load  = 7'b0000011;
  localparam logic [6:0] op_store = 7'b0100011;
  localparam logic [6:0] op_jal   = 7'b1101111;
  localparam logic [6:0] op_jalr  = 7'b1100111;
  localparam logic [6:0] op_auipc = 7'b0010111;

  // ------------------------------
  // Instruction formats
  // ------------------------------
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_hi;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    logic [6:0] opcode;
  } s_fmt_t;

  // Immediate bits arrive as imm[20|10:1|11|19:12].
  typedef struct packed {
    logic [19:0] imm;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } j_fmt_t;

  typedef struct packed {
    logic [19:0] imm;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } u_fmt_t;

  typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
    s_fmt_t s_fmt;
    j_fmt_t j_fmt;
    u_fmt_t u_fmt;
  } instr_t;

endpackage

`default_nettype wire

// ==== logic/rv_ctrl_pkg.sv ====
`default_nettype none

package rv_ctrl_pkg;

  // One execute and one write-back state per instruction class.
  typedef enum logic [3:0] {
    st_fetch,
    st_decode,
    st_ex_addsub,
    st_ex_addi,
    st_ex_load,
    st_ex_store,
    st_ex_jal,
    st_ex_jalr,
    st_ex_auipc,
    st_wb_addsub,
    st_wb_addi,
    st_wb_load,
    st_wb_store,
    st_wb_jal,
    st_wb_jalr,
    st_wb_auipc
  } ctrl_state_t;

  typedef enum logic [1:0] {
    rf_src_mem    = 2'b00,  // Load data.
    rf_src_alu    = 2'b01,
    rf_src_link   = 2'b10,  // PC + 4.
    rf_src_pc_imm = 2'b11
  } rf_src_t;

endpackage

`default_nettype wire

// ==== logic/control_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module control_fsm (
  input  logic                clk,
  input  logic                reset,
  input  logic                run,
  input  logic [6:0]          opcode,
  output logic                load_ir,
  output logic                load_pc,
  output logic                we_rf,
  output logic                we_mem,
  output logic                alu_imm,
  output logic                pc_jump,
  output logic                pc_rel,
  output logic                addr_pc,
  output rv_ctrl_pkg::rf_src_t rf_src
);

  import rv_isa_pkg::*;
  import rv_ctrl_pkg::*;

  ctrl_state_t state, state_next;
  logic        wb_phase;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state <= st_fetch;
    end else begin
      state <= state_next;
    end
  end

  // ------------------------------
  // Next state
  // ------------------------------
  always_comb begin
    state_next = st_fetch;
    case (state)
      st_fetch:     state_next = run ? st_decode : st_fetch;
      st_decode: begin
        case (opcode)
          op_imm:   state_next = st_ex_addi;
          op_load:  state_next = st_ex_load;
          op_store: state_next = st_ex_store;
          op_jal:   state_next = st_ex_jal;
          op_jalr:  state_next = st_ex_jalr;
          op_auipc: state_next = st_ex_auipc;
          default:  state_next = st_ex_addsub;  // Unknown opcodes run as add/sub.
        endcase
      end
      st_ex_addsub: state_next = st_wb_addsub;
      st_ex_addi:   state_next = st_wb_addi;
      st_ex_load:   state_next = st_wb_load;
      st_ex_store:  state_next = st_wb_store;
      st_ex_jal:    state_next = st_wb_jal;
      st_ex_jalr:   state_next = st_wb_jalr;
      st_ex_auipc:  state_next = st_wb_auipc;
      default:      state_next = st_fetch;  // All write-back states end the instruction.
    endcase
  end

  // ------------------------------
  // Output decode
  // ------------------------------
  assign wb_phase = state inside {st_wb_addsub, st_wb_addi, st_wb_load, st_wb_store,
                                  st_wb_jal, st_wb_jalr, st_wb_auipc};

  // Selects are held through execute and write-back so the datapath settles early.
  always_comb begin
    load_ir = 1'b0;
    addr_pc = 1'b0;
    alu_imm = 1'b0;
    pc_jump = 1'b0;
    pc_rel  = 1'b0;
    rf_src  = rf_src_alu;
    case (state)
      st_fetch: begin
        load_ir = run;
        addr_pc = run;
      end
      st_ex_addi, st_wb_addi: begin
        alu_imm = 1'b1;
      end
      st_ex_load, st_wb_load: begin
        alu_imm = 1'b1;
        rf_src  = rf_src_mem;
      end
      st_ex_store, st_wb_store: begin
        alu_imm = 1'b1;
      end
      st_ex_jal, st_wb_jal: begin
        pc_jump = 1'b1;
        pc_rel  = 1'b1;
        rf_src  = rf_src_link;
      end
      st_ex_jalr, st_wb_jalr: begin
        pc_jump = 1'b1;
        rf_src  = rf_src_link;
      end
      st_ex_auipc, st_wb_auipc: begin
        pc_rel = 1'b1;
        rf_src = rf_src_pc_imm;
      end
      default: begin
      end
    endcase
  end

  // The edge that ends write-back commits the instruction.
  assign load_pc = wb_phase;
  assign we_mem  = (state == st_wb_store);
  assign we_rf   = state inside {st_wb_addsub, st_wb_addi, st_wb_load,
                                 st_wb_jal, st_wb_jalr, st_wb_auipc};

  // A commit writes the register file or the memory but never both, and it moves the PC.
  assert property (@(posedge clk) disable iff (reset)
    (we_rf || we_mem) |-> !(we_rf && we_mem) && load_pc);

  // A fetch starts only once the previous instruction has committed.
  assert property (@(posedge clk) disable iff (reset)
    load_ir |-> (state == st_fetch) && ($past(state == st_fetch) || $past(load_pc)));

endmodule

`default_nettype wire

// ==== logic/imm_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module imm_gen (
  input  rv_isa_pkg::instr_t              instr,
  output logic [rv_isa_pkg::xlen-1:0] imm
);

  import rv_isa_pkg::*;

  logic [19:0] j_raw;

  assign j_raw = instr.j_fmt.imm;

  always_comb begin
    case (instr.r_fmt.opcode)
      op_imm, op_load, op_jalr: begin
        imm = {{20{instr.i_fmt.imm[11]}}, instr.i_fmt.imm};
      end
      op_store: begin
        imm = {{20{instr.s_fmt.imm_hi[6]}}, instr.s_fmt.imm_hi, instr.s_fmt.imm_lo};
      end
      op_jal: begin
        // Reorder imm[20|10:1|11|19:12] into imm[20:1].
        imm = {{11{j_raw[19]}}, j_raw[19], j_raw[7:0], j_raw[8], j_raw[18:9], 1'b0};
      end
      op_auipc: begin
        imm = {instr.u_fmt.imm, 12'b0};
      end
      default: imm = '0;  // R format has no immediate.
    endcase
  end

endmodule

`default_nettype wire

// ==== logic/reg_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module reg_file (
  input  logic                        clk,
  input  logic                        reset,
  input  logic [4:0]                  rs1,
  input  logic [4:0]                  rs2,
  input  logic [4:0]                  rd,
  input  logic                        we,
  input  logic [rv_isa_pkg::xlen-1:0] wdata,
  output logic [rv_isa_pkg::xlen-1:0] rdata1,
  output logic [rv_isa_pkg::xlen-1:0] rdata2
);

  import rv_isa_pkg::*;

  logic [xlen-1:0] regs [1:31];  // No storage behind x0.

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we && (rd != 5'd0)) begin
      regs[rd] <= wdata;
    end
  end

  assign rdata1 = (rs1 == 5'd0) ? '0 : regs[rs1];
  assign rdata2 = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

// ==== logic/datapath.sv ====
`timescale 1ns/1ps
`default_nettype none

module datapath (
  input  logic                                 clk,
  input  logic                                 reset,
  input  logic                                 load_ir,
  input  logic                                 load_pc,
  input  logic                                 we_rf,
  input  rv_ctrl_pkg::rf_src_t                 rf_src,
  input  logic                                 alu_imm,
  input  logic                                 pc_jump,
  input  logic                                 pc_rel,
  input  logic                                 addr_pc,
  output logic [6:0]                           opcode,
  output logic [rv_isa_pkg::mem_addr_bits-1:0] mem_addr,
  output logic [rv_isa_pkg::xlen-1:0]          mem_wdata,
  input  logic [rv_isa_pkg::xlen-1:0]          mem_rdata,
  output logic [rv_isa_pkg::xlen-1:0]          pc
);

  import rv_isa_pkg::*;
  import rv_ctrl_pkg::*;

  instr_t          ir;
  logic [xlen-1:0] imm, rs1_data, rs2_data, rf_wdata;
  logic [xlen-1:0] alu_b, alu_y, target_base, target_sum, jump_target;
  logic [xlen-1:0] pc_plus4, pc_next;
  logic            alu_sub;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      pc <= '0;
    end else if (load_pc) begin
      pc <= pc_next;
    end
  end

  always_ff @(posedge clk) begin
    if (load_ir) begin
      ir <= mem_rdata;
    end
  end

  assign opcode = ir.r_fmt.opcode;

  imm_gen u_imm_gen (
    .instr (ir),
    .imm   (imm)
  );

  reg_file u_reg_file (
    .clk    (clk),
    .reset  (reset),
    .rs1    (ir.r_fmt.rs1),
    .rs2    (ir.r_fmt.rs2),
    .rd     (ir.r_fmt.rd),
    .we     (we_rf),
    .wdata  (rf_wdata),
    .rdata1 (rs1_data),
    .rdata2 (rs2_data)
  );

  // ------------------------------
  // ALU and target adder
  // ------------------------------
  assign alu_sub = (ir.r_fmt.opcode == op_op) && ir.r_fmt.funct7[5];
  assign alu_b   = alu_imm ? imm : rs2_data;
  assign alu_y   = alu_sub ? (rs1_data - alu_b) : (rs1_data + alu_b);

  assign target_base = pc_rel ? pc : rs1_data;
  assign target_sum  = target_base + imm;
  assign jump_target = {target_sum[xlen-1:1], 1'b0};  // JALR drops bit 0.

  assign pc_plus4 = pc + 32'd4;
  assign pc_next  = pc_jump ? jump_target : pc_plus4;

  always_comb begin
    case (rf_src)
      rf_src_mem:    rf_wdata = mem_rdata;
      rf_src_link:   rf_wdata = pc_plus4;
      rf_src_pc_imm: rf_wdata = target_sum;
      default:       rf_wdata = alu_y;
    endcase
  end

  // Byte addresses become word addresses.
  assign mem_addr  = addr_pc ? pc[mem_addr_bits+1:2] : alu_y[mem_addr_bits+1:2];
  assign mem_wdata = rs2_data;

  // Jump targets come from the immediate and rs1, so misalignment shows up here.
  assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00);

endmodule

`default_nettype wire

// ==== logic/unified_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

module unified_mem (
  input  logic                                 clk,
  input  logic                                 we,
  input  logic [rv_isa_pkg::mem_addr_bits-1:0] addr,
  input  logic [rv_isa_pkg::xlen-1:0]          wdata,
  output logic [rv_isa_pkg::xlen-1:0]          rdata,
  input  logic                                 dbg_we,
  input  logic [rv_isa_pkg::mem_addr_bits-1:0] dbg_addr,
  input  logic [rv_isa_pkg::xlen-1:0]          dbg_wdata,
  output logic [rv_isa_pkg::xlen-1:0]          dbg_rdata
);

  import rv_isa_pkg::*;

  logic [xlen-1:0] mem [mem_words];

  always_ff @(posedge clk) begin
    if (we) begin
      mem[addr] <= wdata;
    end
    if (dbg_we) begin
      mem[dbg_addr] <= dbg_wdata;
    end
  end

  // Both ports read without a clock.
  assign rdata     = mem[addr];
  assign dbg_rdata = mem[dbg_addr];

  // The debug port is only used while the core is stopped.
  assert property (@(posedge clk) !(we && dbg_we));

endmodule

`default_nettype wire

// ==== logic/rv_multicycle_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_multicycle_top (
  input  logic                                 clk,
  input  logic                                 reset,
  input  logic                                 run,
  input  logic                                 dbg_we,
  input  logic [rv_isa_pkg::mem_addr_bits-1:0] dbg_addr,
  input  logic [rv_isa_pkg::xlen-1:0]          dbg_wdata,
  output logic [rv_isa_pkg::xlen-1:0]          dbg_rdata,
  output logic [rv_isa_pkg::xlen-1:0]          pc
);

  import rv_isa_pkg::*;
  import rv_ctrl_pkg::*;

  logic                     load_ir, load_pc, we_rf, we_mem;
  logic                     alu_imm, pc_jump, pc_rel, addr_pc;
  rf_src_t                  rf_src;
  logic [6:0]               opcode;
  logic [mem_addr_bits-1:0] mem_addr;
  logic [xlen-1:0]          mem_wdata, mem_rdata;

  control_fsm u_control_fsm (
    .clk     (clk),
    .reset   (reset),
    .run     (run),
    .opcode  (opcode),
    .load_ir (load_ir),
    .load_pc (load_pc),
    .we_rf   (we_rf),
    .we_mem  (we_mem),
    .alu_imm (alu_imm),
    .pc_jump (pc_jump),
    .pc_rel  (pc_rel),
    .addr_pc (addr_pc),
    .rf_src  (rf_src)
  );

  datapath u_datapath (
    .clk       (clk),
    .reset     (reset),
    .load_ir   (load_ir),
    .load_pc   (load_pc),
    .we_rf     (we_rf),
    .rf_src    (rf_src),
    .alu_imm   (alu_imm),
    .pc_jump   (pc_jump),
    .pc_rel    (pc_rel),
    .addr_pc   (addr_pc),
    .opcode    (opcode),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_rdata (mem_rdata),
    .pc        (pc)
  );

  unified_mem u_unified_mem (
    .clk       (clk),
    .we        (we_mem),
    .addr      (mem_addr),
    .wdata     (mem_wdata),
    .rdata     (mem_rdata),
    .dbg_we    (dbg_we),
    .dbg_addr  (dbg_addr),
    .dbg_wdata (dbg_wdata),
    .dbg_rdata (dbg_rdata)
  );

endmodule

`default_nettype wire

// ==== sim/tb_rv_multicycle.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_rv_multicycle;

  import rv_isa_pkg::*;

  localparam string input_file = "sim/rv_program_input.txt";

  logic                     clk = 1'b0;
  logic                     reset, run, dbg_we;
  logic [mem_addr_bits-1:0] dbg_addr;
  logic [xlen-1:0]          dbg_wdata, dbg_rdata, pc;

  logic [mem_addr_bits-1:0] prog_addrs [$];
  logic [xlen-1:0]          prog_words [$];
  logic [mem_addr_bits-1:0] result_addrs [$];
  logic [xlen-1:0]          result_words [$];
  logic [xlen-1:0]          exp_mem [mem_words];  // Memory image the run should leave.
  logic [xlen-1:0]          final_pc;
  int                       n_instr = 0;
  int                       cycle_count = 0;
  int                       cycle_limit = 1000;

  rv_multicycle_top uut (
    .clk       (clk),
    .reset     (reset),
    .run       (run),
    .dbg_we    (dbg_we),
    .dbg_addr  (dbg_addr),
    .dbg_wdata (dbg_wdata),
    .dbg_rdata (dbg_rdata),
    .pc        (pc)
  );

  always #20 clk = ~clk;  // 40 ns period.

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      stop_with_failure("Simulation did not finish in time");
    end
  end

  // ------------------------------
  // Helpers
  // ------------------------------
  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("Something failed");
    $fatal(1);
  endtask

  task automatic check_word(input logic [mem_addr_bits-1:0] addr,
                            input logic [xlen-1:0] got, input logic [xlen-1:0] expected);
    if (got !== expected) begin
      stop_with_failure($sformatf("Mismatch at %0t ns: word %0d reads %h, expected %h",
                                  $time, addr, got, expected));
    end
  endtask

  task automatic check_pc(input logic [xlen-1:0] got, input logic [xlen-1:0] expected);
    if (got !== expected) begin
      stop_with_failure($sformatf("Mismatch at %0t ns: pc is %h, expected %h",
                                  $time, got, expected));
    end
  endtask

  // All stimulus changes 2 ns after a rising edge.
  task automatic next_cycle();
    @(posedge clk);
    #2;
  endtask

  task automatic write_word(input logic [mem_addr_bits-1:0] addr, input logic [xlen-1:0] data);
    dbg_we    = 1'b1;
    dbg_addr  = addr;
    dbg_wdata = data;
    next_cycle();
    dbg_we    = 1'b0;
  endtask

  task automatic read_and_check(input logic [mem_addr_bits-1:0] addr);
    dbg_addr = addr;
    @(negedge clk);  // The debug read is combinational and settled by mid cycle.
    check_word(addr, dbg_rdata, exp_mem[addr]);
    next_cycle();
  endtask

  task automatic read_input();
    int              fd;
    int              fields;
    string           line;
    logic [7:0]      tag;
    logic [xlen-1:0] addr, value;
    fd = $fopen(input_file, "r");
    if (fd == 0) begin
      stop_with_failure({"Cannot open the input file ", input_file});
    end
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      fields = $sscanf(line, "%c %h %h", tag, addr, value);
      if (fields == 3 && tag != "#") begin
        case (tag)
          "p": begin
            prog_addrs.push_back(addr[mem_addr_bits-1:0]);
            prog_words.push_back(value);
          end
          "e": begin
            result_addrs.push_back(addr[mem_addr_bits-1:0]);
            result_words.push_back(value);
          end
          "n":     n_instr = int'(value);
          "f":     final_pc = value;
          default: stop_with_failure("The input file holds a line of unknown kind");
        endcase
      end
    end
    $fclose(fd);
    if (n_instr == 0 || prog_words.size() == 0) begin
      stop_with_failure("The input file holds no program or no instruction count");
    end
  endtask

  // ------------------------------
  // Test sequence
  // ------------------------------
  initial begin
    reset     = 1'b1;
    run       = 1'b0;
    dbg_we    = 1'b0;
    dbg_addr  = '0;
    dbg_wdata = '0;
    void'($urandom(75584));
    read_input();
    cycle_limit = 2 * mem_words + prog_words.size() + 4 * n_instr + 200;

    repeat (4) @(posedge clk);
    #2 reset = 1'b0;
    check_pc(pc, '0);

    // Random background first, so a stray store shows up on readback.
    for (int i = 0; i < mem_words; i++) begin
      exp_mem[i] = $urandom();
      write_word(mem_addr_bits'(i), exp_mem[i]);
    end
    foreach (prog_words[i]) begin
      exp_mem[prog_addrs[i]] = prog_words[i];
      write_word(prog_addrs[i], prog_words[i]);
    end

    repeat (8) next_cycle();
    check_pc(pc, '0);  // Core stays put while run is low.

    run = 1'b1;
    repeat (4 * n_instr) next_cycle();
    run = 1'b0;
    check_pc(pc, final_pc);

    foreach (result_words[i]) begin
      exp_mem[result_addrs[i]] = result_words[i];
    end
    repeat (8) next_cycle();
    check_pc(pc, final_pc);
    for (int i = 0; i < mem_words; i++) begin
      read_and_check(mem_addr_bits'(i));
    end

    $display("Everything OK");
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim/rv_program_input.txt ====
# kind word_addr value, both hex. p is a program word, e an expected memory word after the run.
# n is the instruction count and f the final pc; their address column is unused.
p 00 06400093  # 0x00 addi x1, x0, 100
p 01 FE200113  # 0x04 addi x2, x0, -30
p 02 002081B3  # 0x08 add  x3, x1, x2
p 03 40110233  # 0x0C sub  x4, x2, x1
p 04 10302023  # 0x10 sw   x3, 0x100(x0)
p 05 10402223  # 0x14 sw   x4, 0x104(x0)
p 06 10002283  # 0x18 lw   x5, 0x100(x0)
p 07 FFF28313  # 0x1C addi x6, x5, -1
p 08 10602423  # 0x20 sw   x6, 0x108(x0)
p 09 00C003EF  # 0x24 jal  x7, +12
p 0a 00100193  # 0x28 addi x3, x0, 1 (skipped)
p 0b 10302023  # 0x2C sw   x3, 0x100(x0) (skipped)
p 0c 10702623  # 0x30 sw   x7, 0x10C(x0)
p 0d 12345417  # 0x34 auipc x8, 0x12345
p 0e 10802823  # 0x38 sw   x8, 0x110(x0)
p 0f 03700013  # 0x3C addi x0, x0, 55
p 10 10002A23  # 0x40 sw   x0, 0x114(x0)
p 11 05100493  # 0x44 addi x9, x0, 0x51
p 12 00448567  # 0x48 jalr x10, 4(x9)
p 13 10102023  # 0x4C sw   x1, 0x100(x0) (skipped)
p 14 10102223  # 0x50 sw   x1, 0x104(x0) (skipped)
p 15 10A02C23  # 0x54 sw   x10, 0x118(x0)
p 16 10402583  # 0x58 lw   x11, 0x104(x0)
p 17 10B02E23  # 0x5C sw   x11, 0x11C(x0)
n 00 00000014
e 40 00000046
e 41 FFFFFF7E
e 42 00000045
e 43 00000028
e 44 12345034
e 45 00000000
e 46 0000004C
e 47 FFFFFF7E
f 00 00000060

// ==== rv_multicycle.f ====
logic/rv_isa_pkg.sv
logic/rv_ctrl_pkg.sv
logic/control_fsm.sv
logic/imm_gen.sv
logic/reg_file.sv
logic/datapath.sv
logic/unified_mem.sv
logic/rv_multicycle_top.sv
sim/tb_rv_multicycle.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it, and searches the log for the pass line.
cd "$(dirname "$0")" || exit 1
rm -f sim_run.log

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_rv_multicycle -f rv_multicycle.f -o tb_rv_multicycle \
  && ./obj_dir/tb_rv_multicycle 2>&1 | tee sim_run.log \
  && grep -qx "Everything OK" sim_run.log \
  && echo "PASS" \
  || { echo "FAIL"; exit 1; }
